//--- bus_soc.f
+incdir+hdl
hdl/bus_soc_pkg.sv
hdl/word_ram.sv
hdl/machine_timer.sv
hdl/irq_controller.sv
hdl/bus_sequencer.sv
hdl/bus_soc_top.sv
testbench/bus_soc_tb.sv

//--- hdl/bus_sequencer.sv
`timescale 1ns/1ns
`include "bus_soc_defines.svh"

module bus_sequencer import bus_soc_pkg::*; (
    input  logic                   clock_1hz,
    input  logic                   KEY0,
    input  bus_req_t               bus_req,
    input  logic                   bus_read_enable,
    input  logic                   bus_write_enable,
    input  logic [31:0]            ram_rdata,
    input  logic [`BUS_DATA_W-1:0] reg_rdata_timer,
    input  logic [`BUS_DATA_W-1:0] reg_rdata_irq,
    output ram_access_t            ram_acc,
    output reg_access_t            reg_acc,
    output logic [`BUS_DATA_W-1:0] bus_read_data,
    output logic                   bus_read_done,
    output logic                   bus_write_done
);

    typedef enum logic [1:0] {st_idle, st_beat0, st_beat1, st_finish} state_t;
    typedef enum logic [1:0] {tgt_none, tgt_ram, tgt_reg} target_t;

    state_t                  state;
    target_t                 dec_tgt;
    reg_sel_t                dec_sel;
    target_t                 cap_tgt;
    logic                    cap_write;
    reg_sel_t                cap_sel;
    logic [2:0]              cap_slot;
    logic [`RAM_INDEX_W-1:0] cap_index;
    logic [1:0]              cap_off;
    ls_type_t                cap_ls;
    logic [`BUS_DATA_W-1:0]  cap_wdata;
    logic [3:0]              byte_en;
    logic [31:0]             lane;
    logic [`BUS_DATA_W-1:0]  load_value;

    // address decode, done once on the request as it is sampled
    always_comb begin
        dec_tgt = tgt_reg;
        dec_sel = sel_mtime;
        if (bus_req.addr >= `RAM_BASE && bus_req.addr < `RAM_BASE + 4 * `RAM_WORDS)
            dec_tgt = tgt_ram;
        else if (bus_req.addr == `MTIME_ADDR)
            dec_sel = sel_mtime;
        else if (bus_req.addr == `MTIMECMP_ADDR)
            dec_sel = sel_mtimecmp;
        else if (bus_req.addr >= `PLIC_BASE && bus_req.addr < `PLIC_BASE + 4 * `PLIC_SOURCES)
            dec_sel = sel_priority;
        else if (bus_req.addr == `PLIC_PENDING)
            dec_sel = sel_pending;
        else if (bus_req.addr == `PLIC_ENABLE)
            dec_sel = sel_enable0;
        else if (bus_req.addr == `PLIC_ENABLE + `PLIC_ENABLE_STRIDE)
            dec_sel = sel_enable1;
        else if (bus_req.addr == `PLIC_THRESHOLD)
            dec_sel = sel_threshold0;
        else if (bus_req.addr == `PLIC_THRESHOLD + `PLIC_CTX_STRIDE)
            dec_sel = sel_threshold1;
        else if (bus_req.addr == `PLIC_CLAIM)
            dec_sel = sel_claim0;
        else if (bus_req.addr == `PLIC_CLAIM + `PLIC_CTX_STRIDE)
            dec_sel = sel_claim1;
        else
            dec_tgt = tgt_none;
    end

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            state          <= st_idle;
            cap_tgt        <= tgt_none;
            cap_write      <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (bus_read_enable || bus_write_enable) begin
                        cap_tgt   <= dec_tgt;
                        cap_write <= bus_write_enable;
                        if (bus_read_enable)
                            bus_read_done <= 1'b0;
                        if (bus_write_enable)
                            bus_write_done <= 1'b0;
                        state <= (dec_tgt == tgt_ram) ? st_beat0 : st_finish;
                    end
                end
                st_beat0: begin
                    // ld and sd code 3 take a second beat
                    if (cap_ls == ls_ld) begin
                        if (!cap_write)
                            bus_read_data[31:0] <= ram_rdata;
                        state <= st_beat1;
                    end else begin
                        if (!cap_write)
                            bus_read_data <= load_value;
                        bus_read_done  <= 1'b1;
                        bus_write_done <= 1'b1;
                        state          <= st_idle;
                    end
                end
                st_beat1: begin
                    if (!cap_write)
                        bus_read_data[63:32] <= ram_rdata;
                    bus_read_done  <= 1'b1;
                    bus_write_done <= 1'b1;
                    state          <= st_idle;
                end
                default: begin
                    // unmapped reads return zero
                    if (!cap_write)
                        bus_read_data <= (cap_tgt == tgt_reg) ? (reg_rdata_timer | reg_rdata_irq) : '0;
                    bus_read_done  <= 1'b1;
                    bus_write_done <= 1'b1;
                    state          <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock_1hz) begin
        if (state == st_idle && (bus_read_enable || bus_write_enable)) begin
            cap_sel   <= dec_sel;
            cap_slot  <= bus_req.addr[4:2];
            cap_index <= bus_req.addr[`RAM_INDEX_W+1:2];
            cap_off   <= bus_req.addr[1:0];
            cap_ls    <= bus_req.ls_type;
            cap_wdata <= bus_req.wdata;
        end
    end

    // byte lanes for sb and sh
    always_comb begin
        case (cap_ls)
            ls_lb:   byte_en = 4'b0001 << cap_off;
            ls_lh:   byte_en = 4'b0011 << cap_off;
            default: byte_en = 4'b1111;
        endcase
    end

    assign lane = ram_rdata >> {cap_off, 3'b000};

    always_comb begin
        case (cap_ls)
            ls_lb:   load_value = {{56{lane[7]}}, lane[7:0]};
            ls_lh:   load_value = {{48{lane[15]}}, lane[15:0]};
            ls_lw:   load_value = {{32{lane[31]}}, lane};
            ls_lbu:  load_value = {56'b0, lane[7:0]};
            ls_lhu:  load_value = {48'b0, lane[15:0]};
            default: load_value = {32'b0, lane};
        endcase
    end

    // idle presents the incoming index so read data is ready in beat0
    always_comb begin
        ram_acc.index   = cap_index;
        ram_acc.wdata   = cap_wdata[31:0] << {cap_off, 3'b000};
        ram_acc.byte_en = byte_en;
        ram_acc.write   = 1'b0;
        case (state)
            st_idle: ram_acc.index = bus_req.addr[`RAM_INDEX_W+1:2];
            st_beat0: begin
                ram_acc.write = cap_write;
                if (!cap_write && cap_ls == ls_ld)
                    ram_acc.index = cap_index + 1'b1;
            end
            st_beat1: begin
                ram_acc.index   = cap_index + 1'b1;
                ram_acc.wdata   = cap_wdata[63:32];
                ram_acc.byte_en = 4'b1111;
                ram_acc.write   = cap_write;
            end
            default: ram_acc.write = 1'b0;
        endcase
    end

    always_comb begin
        reg_acc.sel   = cap_sel;
        reg_acc.slot  = cap_slot;
        reg_acc.wdata = cap_wdata;
        reg_acc.wr    = (state == st_finish) && (cap_tgt == tgt_reg) && cap_write;
        reg_acc.rd    = (state == st_finish) && (cap_tgt == tgt_reg) && !cap_write;
    end

    a_one_enable: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable));

    // master waits for done before the next request
    a_no_enable_busy: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        (state != st_idle) |-> !(bus_read_enable || bus_write_enable));

endmodule

//--- hdl/bus_soc_defines.svh
`ifndef BUS_SOC_DEFINES_SVH
`define BUS_SOC_DEFINES_SVH

// on-chip RAM window
`define RAM_BASE            32'h8000_0000
`define RAM_WORDS           512
`define RAM_INDEX_W         9

// machine timer
`define MTIME_ADDR          32'h0200_BFF8
`define MTIMECMP_ADDR       32'h0200_4000
`define MTIMECMP_RESET      64'h0000_0000_8000_0000

// interrupt controller, one priority word per source id
`define PLIC_BASE           32'h0C00_0000
`define PLIC_SOURCES        6
`define PLIC_PENDING        (`PLIC_BASE + 32'h0000_1000)
`define PLIC_ENABLE         (`PLIC_BASE + 32'h0000_2000)
`define PLIC_THRESHOLD      (`PLIC_BASE + 32'h0020_0000)
`define PLIC_CLAIM          (`PLIC_THRESHOLD + 32'h0000_0004)
// per-context spacing
`define PLIC_ENABLE_STRIDE  32'h0000_0080
`define PLIC_CTX_STRIDE     32'h0000_1000

`define BUS_DATA_W          64

`endif

//--- hdl/bus_soc_pkg.sv
`include "bus_soc_defines.svh"

package bus_soc_pkg;

    // stores reuse codes 0..3 as sb, sh, sw, sd
    typedef enum logic [2:0] {
        ls_lb  = 3'd0,
        ls_lh  = 3'd1,
        ls_lw  = 3'd2,
        ls_ld  = 3'd3,
        ls_lbu = 3'd4,
        ls_lhu = 3'd5,
        ls_lwu = 3'd6
    } ls_type_t;

    typedef struct packed {
        logic [31:0]              addr;
        logic [`BUS_DATA_W-1:0]   wdata;
        ls_type_t                 ls_type;
    } bus_req_t;

    typedef struct packed {
        logic [`RAM_INDEX_W-1:0]  index;
        logic [31:0]              wdata;
        logic [3:0]               byte_en;
        logic                     write;
    } ram_access_t;

    typedef enum logic [3:0] {
        sel_mtime, sel_mtimecmp, sel_priority, sel_pending,
        sel_enable0, sel_enable1, sel_threshold0, sel_threshold1,
        sel_claim0, sel_claim1
    } reg_sel_t;

    // slot carries the priority source id next to the register code
    typedef struct packed {
        reg_sel_t                 sel;
        logic [2:0]               slot;
        logic                     wr;
        logic                     rd;
        logic [`BUS_DATA_W-1:0]   wdata;
    } reg_access_t;

endpackage

//--- hdl/bus_soc_top.sv
`timescale 1ns/1ns
`include "bus_soc_defines.svh"

module bus_soc_top import bus_soc_pkg::*; (
    input  logic                   clock_1hz,
    input  logic                   KEY0,
    input  bus_req_t               bus_req,
    input  logic                   bus_read_enable,
    input  logic                   bus_write_enable,
    input  logic                   irq_line,
    output logic [`BUS_DATA_W-1:0] bus_read_data,
    output logic                   bus_read_done,
    output logic                   bus_write_done,
    output logic                   meip_interrupt,
    output logic                   msip_interrupt,
    output logic                   timer_irq
);

    ram_access_t             ram_acc;
    logic [31:0]             ram_rdata;
    reg_access_t             reg_acc;
    logic [`BUS_DATA_W-1:0]  reg_rdata_timer;
    logic [`BUS_DATA_W-1:0]  reg_rdata_irq;

    bus_sequencer u_sequencer (
        .clock_1hz        (clock_1hz),
        .KEY0             (KEY0),
        .bus_req          (bus_req),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .ram_rdata        (ram_rdata),
        .reg_rdata_timer  (reg_rdata_timer),
        .reg_rdata_irq    (reg_rdata_irq),
        .ram_acc          (ram_acc),
        .reg_acc          (reg_acc),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done)
    );

    word_ram u_ram (
        .clock_1hz (clock_1hz),
        .ram_acc   (ram_acc),
        .ram_rdata (ram_rdata)
    );

    machine_timer u_timer (
        .clock_1hz       (clock_1hz),
        .KEY0            (KEY0),
        .reg_acc         (reg_acc),
        .reg_rdata_timer (reg_rdata_timer),
        .timer_irq       (timer_irq)
    );

    irq_controller u_plic (
        .clock_1hz      (clock_1hz),
        .KEY0           (KEY0),
        .irq_line       (irq_line),
        .reg_acc        (reg_acc),
        .reg_rdata_irq  (reg_rdata_irq),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

//--- hdl/irq_controller.sv
`timescale 1ns/1ns
`include "bus_soc_defines.svh"

module irq_controller import bus_soc_pkg::*; (
    input  logic                   clock_1hz,
    input  logic                   KEY0,
    input  logic                   irq_line,
    input  reg_access_t            reg_acc,
    output logic [`BUS_DATA_W-1:0] reg_rdata_irq,
    output logic                   meip_interrupt,
    output logic                   msip_interrupt
);

    logic [2:0]  prio [0:`PLIC_SOURCES-1];
    logic [31:0] pending;
    logic [31:0] enable [0:1];
    logic [2:0]  threshold [0:1];
    logic        irq_sync;
    logic        irq_prev;
    logic        irq_rise;
    logic [1:0]  ctx_irq;
    logic        claim_hit;

    assign irq_rise = irq_sync && !irq_prev;

    // source 1 is the only wired source
    assign ctx_irq[0]     = pending[1] && enable[0][1];
    assign ctx_irq[1]     = pending[1] && enable[1][1];
    assign meip_interrupt = ctx_irq[0];
    assign msip_interrupt = ctx_irq[1];

    assign claim_hit = reg_acc.rd && ((reg_acc.sel == sel_claim0 && ctx_irq[0])
                                   || (reg_acc.sel == sel_claim1 && ctx_irq[1]));

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            irq_sync  <= 1'b0;
            irq_prev  <= 1'b0;
            pending   <= '0;
            enable    <= '{default: '0};
            threshold <= '{default: '0};
            prio      <= '{default: '0};
        end else begin
            irq_sync <= irq_line;
            irq_prev <= irq_sync;
            if (claim_hit)
                pending[1] <= 1'b0;
            // a new edge wins over a claim in the same cycle
            if (irq_rise)
                pending[1] <= 1'b1;
            if (reg_acc.wr) begin
                case (reg_acc.sel)
                    sel_priority:   prio[reg_acc.slot] <= reg_acc.wdata[2:0];
                    sel_enable0:    enable[0] <= reg_acc.wdata[31:0];
                    sel_enable1:    enable[1] <= reg_acc.wdata[31:0];
                    sel_threshold0: threshold[0] <= reg_acc.wdata[2:0];
                    sel_threshold1: threshold[1] <= reg_acc.wdata[2:0];
                    default:        ;
                endcase
            end
        end
    end

    always_comb begin
        reg_rdata_irq = '0;
        case (reg_acc.sel)
            sel_priority:   reg_rdata_irq[2:0] = prio[reg_acc.slot];
            sel_pending:    reg_rdata_irq[31:0] = pending;
            sel_enable0:    reg_rdata_irq[31:0] = enable[0];
            sel_enable1:    reg_rdata_irq[31:0] = enable[1];
            sel_threshold0: reg_rdata_irq[2:0] = threshold[0];
            sel_threshold1: reg_rdata_irq[2:0] = threshold[1];
            sel_claim0:     reg_rdata_irq[0] = ctx_irq[0];
            sel_claim1:     reg_rdata_irq[0] = ctx_irq[1];
            default:        reg_rdata_irq = '0;
        endcase
    end

    a_claim_id: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        (reg_acc.rd && (reg_acc.sel == sel_claim0 || reg_acc.sel == sel_claim1))
        |-> (reg_rdata_irq <= 1));

endmodule

//--- hdl/machine_timer.sv
`timescale 1ns/1ns
`include "bus_soc_defines.svh"

module machine_timer import bus_soc_pkg::*; (
    input  logic                   clock_1hz,
    input  logic                   KEY0,
    input  reg_access_t            reg_acc,
    output logic [`BUS_DATA_W-1:0] reg_rdata_timer,
    output logic                   timer_irq
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;

    // mtime is read only from the bus
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            mtime    <= '0;
            mtimecmp <= `MTIMECMP_RESET;
        end else begin
            mtime <= mtime + 1'b1;
            if (reg_acc.wr && reg_acc.sel == sel_mtimecmp)
                mtimecmp <= reg_acc.wdata;
        end
    end

    always_comb begin
        case (reg_acc.sel)
            sel_mtime:    reg_rdata_timer = mtime;
            sel_mtimecmp: reg_rdata_timer = mtimecmp;
            default:      reg_rdata_timer = '0;
        endcase
    end

    assign timer_irq = (mtime >= mtimecmp);

endmodule

//--- hdl/word_ram.sv
`timescale 1ns/1ns
`include "bus_soc_defines.svh"

module word_ram import bus_soc_pkg::*; (
    input  logic        clock_1hz,
    input  ram_access_t ram_acc,
    output logic [31:0] ram_rdata
);

    logic [31:0] mem [0:`RAM_WORDS-1];

    initial begin
        for (int i = 0; i < `RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // per-byte write, old word on the read port
    always_ff @(posedge clock_1hz) begin
        for (int b = 0; b < 4; b++) begin
            if (ram_acc.write && ram_acc.byte_en[b])
                mem[ram_acc.index][8*b +: 8] <= ram_acc.wdata[8*b +: 8];
        end
        ram_rdata <= mem[ram_acc.index];
    end

    a_write_lanes: assert property (@(posedge clock_1hz)
        ram_acc.write |-> (ram_acc.byte_en != 4'b0000));

endmodule

//--- testbench/bus_soc_tb.sv
`timescale 1ns/1ns
`include "bus_soc_defines.svh"

module bus_soc_tb import bus_soc_pkg::*; ();

    localparam int max_tests = 64;

    logic             clock_1hz;
    logic             KEY0;
    bus_req_t         bus_req;
    logic             bus_read_enable;
    logic             bus_write_enable;
    logic             irq_line;
    logic [63:0]      bus_read_data;
    logic             bus_read_done;
    logic             bus_write_done;
    logic             meip_interrupt;
    logic             msip_interrupt;
    logic             timer_irq;

    // one row per test line of the data file
    logic [8*8-1:0]   op_mem   [0:max_tests-1];
    logic [8*24-1:0]  name_mem [0:max_tests-1];
    logic [2:0]       ls_mem   [0:max_tests-1];
    logic [31:0]      addr_mem [0:max_tests-1];
    logic [63:0]      data_mem [0:max_tests-1];
    logic [63:0]      exp_mem  [0:max_tests-1];
    integer           n_tests;
    logic             loaded;
    integer           seed;

    bus_soc_top uut (
        .clock_1hz        (clock_1hz),
        .KEY0             (KEY0),
        .bus_req          (bus_req),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .irq_line         (irq_line),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .meip_interrupt   (meip_interrupt),
        .msip_interrupt   (msip_interrupt),
        .timer_irq        (timer_irq)
    );

    initial begin
        clock_1hz = 1'b0;
        forever #50 clock_1hz = ~clock_1hz;
    end

    task automatic check_value(input logic [8*24-1:0] name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %0s: expected %h, actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    // comment lines start with a lone # token
    task automatic load_tests;
        integer           fd;
        integer           rc;
        integer           ls_tmp;
        logic [8*8-1:0]   op;
        logic [8*24-1:0]  name;
        logic [31:0]      addr;
        logic [63:0]      data;
        logic [63:0]      expected;
        logic [8*120-1:0] rest;
        n_tests = 0;
        fd = $fopen("testbench/bus_soc_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            $display("Test FAILED");
            $fatal(1, "no test data");
        end else begin
            rc = $fscanf(fd, "%s", op);
            while (rc == 1) begin
                if (op == "#") begin
                    rc = $fgets(rest, fd);
                end else begin
                    rc = $fscanf(fd, "%s %d %h %h %h", name, ls_tmp, addr, data, expected);
                    if (rc != 5 || n_tests >= max_tests) begin
                        $display("Test data line %0d is malformed or too many lines", n_tests);
                        $display("Test FAILED");
                        $fatal(1, "bad test data");
                    end else begin
                        op_mem[n_tests]   = op;
                        name_mem[n_tests] = name;
                        ls_mem[n_tests]   = ls_tmp[2:0];
                        addr_mem[n_tests] = addr;
                        data_mem[n_tests] = data;
                        exp_mem[n_tests]  = expected;
                        n_tests = n_tests + 1;
                    end
                end
                rc = $fscanf(fd, "%s", op);
            end
            $fclose(fd);
        end
    endtask

    // one request, held until the matching done is back
    task automatic bus_access(input logic [8*24-1:0] name, input logic write,
                              input logic [2:0] ls, input logic [31:0] addr,
                              input logic [63:0] data, output logic [63:0] rdata);
        integer cycles;
        logic   two_beat;
        // ld and sd into RAM take two beats, everything else one
        two_beat = (ls == 3'd3) && (addr >= `RAM_BASE)
                   && (addr < `RAM_BASE + 4 * `RAM_WORDS);
        @(negedge clock_1hz);
        bus_req.addr     = addr;
        bus_req.wdata    = data;
        bus_req.ls_type  = ls_type_t'(ls);
        bus_write_enable = write;
        bus_read_enable  = !write;
        @(negedge clock_1hz);
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        // only the matching done drops
        check_value(name, write ? 64'd2 : 64'd1, {62'b0, bus_read_done, bus_write_done});
        cycles = 0;
        while (!(bus_read_done && bus_write_done)) begin
            @(negedge clock_1hz);
            cycles = cycles + 1;
        end
        check_value(name, two_beat ? 64'd2 : 64'd1, cycles);
        rdata = bus_read_data;
    endtask

    task automatic pulse_irq;
        @(negedge clock_1hz);
        irq_line = 1'b1;
        repeat (2) @(negedge clock_1hz);
        irq_line = 1'b0;
        // edge reaches pending two cycles after the rise
        repeat (3) @(negedge clock_1hz);
    endtask

    function automatic logic irq_pin(input logic [31:0] sel);
        case (sel)
            32'd0:   irq_pin = meip_interrupt;
            32'd1:   irq_pin = msip_interrupt;
            default: irq_pin = timer_irq;
        endcase
    endfunction

    initial begin
        integer      i;
        integer      gap;
        logic [63:0] rdata;
        logic [63:0] last_tgt;
        KEY0             = 1'b0;
        bus_req          = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        irq_line         = 1'b0;
        seed             = 16;
        loaded           = 1'b0;
        last_tgt         = '0;
        load_tests;
        loaded = 1'b1;
        repeat (10) @(negedge clock_1hz);
        // outputs while reset is held
        check_value("reset_done", 64'd3, {62'b0, bus_read_done, bus_write_done});
        check_value("reset_rdata", 64'd0, bus_read_data);
        check_value("reset_irqs", 64'd0, {61'b0, meip_interrupt, msip_interrupt, timer_irq});
        KEY0 = 1'b1;
        for (i = 0; i < n_tests; i++) begin
            // short random idle gap between lines
            gap = $random(seed) & 3;
            repeat (gap) @(negedge clock_1hz);
            case (op_mem[i])
                "W": begin
                    bus_access(name_mem[i], 1'b1, ls_mem[i], addr_mem[i], data_mem[i], rdata);
                end
                "R": begin
                    bus_access(name_mem[i], 1'b0, ls_mem[i], addr_mem[i], data_mem[i], rdata);
                    check_value(name_mem[i], exp_mem[i], rdata);
                end
                "TGT": begin
                    // must exceed the previous TGT read
                    bus_access(name_mem[i], 1'b0, ls_mem[i], addr_mem[i], data_mem[i], rdata);
                    check_value(name_mem[i], 64'd1, {63'b0, rdata > last_tgt});
                    last_tgt = rdata;
                end
                "PULSE": begin
                    pulse_irq;
                end
                "IRQ": begin
                    @(negedge clock_1hz);
                    check_value(name_mem[i], exp_mem[i], {63'b0, irq_pin(addr_mem[i])});
                end
                default: begin
                    $display("Unknown operation in test line %0d", i);
                    $display("Test FAILED");
                    $fatal(1, "bad operation");
                end
            endcase
        end
        $display("Test OK");
        $finish;
    end

    // budget of 50 clock cycles per test line
    initial begin
        wait (loaded);
        #(n_tests * 5000);
        $display("Watchdog expired, the bus did not finish the tests in time");
        $display("Test FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- testbench/bus_soc_tests.txt
# op name ls_type addr data expected, all hex except ls_type
# ls_type 0 b 1 h 2 w 3 d 4 bu 5 hu 6 wu, IRQ addr 0 meip 1 msip 2 timer, TGT must grow
W sw_word 2 80000000 12345678 0
R lw_word 2 80000000 0 12345678
W sd_double 3 80000008 1122334455667788 0
R ld_double 3 80000008 0 1122334455667788
W sw_neg 2 80000010 80000001 0
R lw_sign 2 80000010 0 ffffffff80000001
R lwu_zero 6 80000010 0 80000001
W sb_lane0 0 80000020 11 0
W sb_lane1 0 80000021 92 0
W sb_lane2 0 80000022 33 0
W sb_lane3 0 80000023 44 0
R lw_bytes 2 80000020 0 44339211
R lb_sign 0 80000021 0 ffffffffffffff92
R lbu_zero 4 80000021 0 92
R lh_sign 1 80000020 0 ffffffffffff9211
R lhu_zero 5 80000020 0 9211
W sh_upper 1 80000032 8001 0
R lw_half_upper 2 80000030 0 ffffffff80010000
R mtimecmp_rst 3 02004000 0 80000000
W mtimecmp_wr 3 02004000 123456789 0
R mtimecmp_rd 3 02004000 0 123456789
TGT mtime_first 3 0200bff8 0 0
TGT mtime_second 3 0200bff8 0 0
W mtimecmp_one 3 02004000 1 0
IRQ timer_irq_on 0 2 0 1
W mtimecmp_max 3 02004000 ffffffffffffffff 0
IRQ timer_irq_off 0 2 0 0
W prio1_wr 2 0c000004 f 0
W prio5_wr 2 0c000014 5 0
R prio1_rd 2 0c000004 0 7
R prio5_rd 2 0c000014 0 5
W thresh0_wr 2 0c200000 1a 0
R thresh0_rd 2 0c200000 0 2
W thresh1_wr 2 0c201000 3 0
R thresh1_rd 2 0c201000 0 3
W enable1_wr 3 0c002080 ffffffff00000005 0
R enable1_rd 3 0c002080 0 5
W unmapped_wr 2 40000000 abcd 0
R unmapped_rd 2 40000000 0 0
R prio_slot6 2 0c000018 0 0
W enable0_wr 2 0c002000 2 0
R enable0_rd 2 0c002000 0 2
R pending_idle 2 0c001000 0 0
PULSE irq_pulse 0 0 0 0
R pending_set 2 0c001000 0 2
IRQ meip_on 0 0 0 1
IRQ msip_off 0 1 0 0
R claim0_hit 2 0c200004 0 1
R pending_clr 2 0c001000 0 0
IRQ meip_off 0 0 0 0
R claim0_none 2 0c200004 0 0
